/* design/mem_pkg.sv */
// ================================================
// Memory types for the inspection panel
// Byte RAM widths and the host write request
// ================================================
`default_nettype none

package mem_pkg;

    // Four hex digits of address, two of data
    localparam int addr_w = 16;
    localparam int data_w = 8;

    typedef logic [addr_w-1:0] addr_t;
    typedef logic [data_w-1:0] data_t;

    // One write request toward the RAM write port
    typedef struct packed {
        logic  en;
        addr_t addr;
        data_t data;
    } mem_wr_t;

endpackage

`default_nettype wire

/* design/panel_pkg.sv */
// ================================================
// Display types for the inspection panel
// Six active-low seven-segment digits
// ================================================
`default_nettype none

package panel_pkg;

    // Digits on the board, four for address and two for data
    localparam int num_digits = 6;

    // One digit, active low
    // Bit 0 is segment a, bit 6 is segment g
    typedef logic [6:0] seg_t;

    // Whole display, leftmost digit in the top bits
    typedef struct packed {
        // Address, high nibble first
        seg_t hex5;
        seg_t hex4;
        seg_t hex3;
        seg_t hex2;
        // Stored byte
        seg_t hex1;
        seg_t hex0;
    } hex_display_t;

endpackage

`default_nettype wire

/* design/address_navigator.sv */
// ================================================
// Manual address navigator
// Key edge detection and a saturating up/down counter
// ================================================
`timescale 1ns/1ps
`default_nettype none

module address_navigator #(
    parameter int mem_depth = 65536
) (
    input  wire logic            clk,
    input  wire logic            reset_n,
    // Active low, bit 0 up and bit 1 down
    input  wire logic [1:0]      keys,
    output mem_pkg::addr_t       manual_addr
);

    // Top address reachable with the up key
    localparam mem_pkg::addr_t max_addr = mem_pkg::addr_t'(mem_depth - 1);

    // ================================================
    // Key sampling
    // ================================================
    // First stage samples the pins, second holds the previous level
    logic [1:0] key_q;
    logic [1:0] key_q_d;
    logic       up_press;
    logic       down_press;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            // Keys read as released
            key_q   <= 2'b11;
            key_q_d <= 2'b11;
        end else begin
            key_q   <= keys;
            key_q_d <= key_q;
        end
    end

    // High-to-low only, so a held key counts once
    assign up_press   = key_q_d[0] && !key_q[0];
    assign down_press = key_q_d[1] && !key_q[1];

    // ================================================
    // Saturating address counter
    // ================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            manual_addr <= '0;
        end else if (down_press && manual_addr != '0) begin
            // Down takes priority when both keys land together
            manual_addr <= manual_addr - 1'b1;
        end else if (up_press && manual_addr != max_addr) begin
            manual_addr <= manual_addr + 1'b1;
        end
    end

    // Counter stays inside the populated memory
    manual_addr_in_range: assert property (
        @(posedge clk) disable iff (!reset_n) manual_addr <= max_addr
    ) else $error("manual address beyond top of memory");

endmodule

`default_nettype wire

/* design/ram_access_select.sv */
// ================================================
// RAM access select
// Host write strobe on data change, read address mux
// ================================================
`timescale 1ns/1ps
`default_nettype none

module ram_access_select (
    input  wire logic            clk,
    input  wire logic            reset_n,
    // 0 follows host, 1 follows manual keys
    input  wire logic            display_mode,
    input  mem_pkg::addr_t       host_addr,
    input  mem_pkg::data_t       host_data,
    input  mem_pkg::addr_t       manual_addr,
    output mem_pkg::mem_wr_t     wr_req,
    output mem_pkg::addr_t       rd_addr
);

    // ================================================
    // Change detection on the host data pins
    // ================================================
    mem_pkg::data_t host_data_prev;
    logic           wr_strobe;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            // Zero copy, so nonzero data at release writes once
            host_data_prev <= '0;
            wr_strobe      <= 1'b0;
        end else begin
            host_data_prev <= host_data;
            // One-cycle pulse per change of data
            wr_strobe      <= (host_data != host_data_prev);
        end
    end

    // Write request taken from the live pins
    // Host holds address and data for two cycles
    always_comb begin
        wr_req.en   = wr_strobe;
        wr_req.addr = host_addr;
        wr_req.data = host_data;
    end

    // Read port and display follow the selected source
    assign rd_addr = display_mode ? manual_addr : host_addr;

    // Steady host data never produces back-to-back writes
    single_write_per_change: assert property (
        @(posedge clk) disable iff (!reset_n)
        (wr_req.en && $stable(host_data)) |=> !wr_req.en
    ) else $error("repeated write strobe with stable host data");

endmodule

`default_nettype wire

/* design/dual_port_ram.sv */
// ================================================
// Dual-port byte RAM
// One synchronous write port, one registered read port
// ================================================
`timescale 1ns/1ps
`default_nettype none

module dual_port_ram #(
    parameter int mem_depth = 65536
) (
    input  wire logic            clk,
    input  mem_pkg::mem_wr_t     wr_req,
    input  mem_pkg::addr_t       rd_addr,
    output mem_pkg::data_t       rd_data
);

    // Index bits actually decoded
    localparam int idx_w = $clog2(mem_depth);

    mem_pkg::data_t mem [mem_depth];

    // Memory powers up cleared
    initial begin
        for (int i = 0; i < mem_depth; i++) begin
            mem[i] = '0;
        end
    end

    // Write port
    always_ff @(posedge clk) begin
        if (wr_req.en) begin
            mem[wr_req.addr[idx_w-1:0]] <= wr_req.data;
        end
    end

    // Read port, old byte on a same-cycle collision
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr[idx_w-1:0]];
    end

    // Host must stay inside the populated memory
    write_addr_in_range: assert property (
        @(posedge clk) wr_req.en |-> (32'(wr_req.addr) < mem_depth)
    ) else $error("write address beyond memory depth");

endmodule

`default_nettype wire

/* design/hex_display_driver.sv */
// ================================================
// Hex display driver
// Address and byte onto six active-low digits
// ================================================
`timescale 1ns/1ps
`default_nettype none

module hex_display_driver (
    input  mem_pkg::addr_t          addr,
    input  mem_pkg::data_t          data,
    output panel_pkg::hex_display_t hex
);

    // ================================================
    // Nibble to segment encoding
    // ================================================
    // Bit order g..a, a lit segment is a 0
    function automatic panel_pkg::seg_t hex_to_seg(input logic [3:0] nib);
        panel_pkg::seg_t seg;
        case (nib)
            4'h0: seg = 7'b1000000;
            4'h1: seg = 7'b1111001;
            4'h2: seg = 7'b0100100;
            4'h3: seg = 7'b0110000;
            4'h4: seg = 7'b0011001;
            4'h5: seg = 7'b0010010;
            4'h6: seg = 7'b0000010;
            4'h7: seg = 7'b1111000;
            4'h8: seg = 7'b0000000;
            4'h9: seg = 7'b0010000;
            // Letters, b and d in lower case
            4'ha: seg = 7'b0001000;
            4'hb: seg = 7'b0000011;
            4'hc: seg = 7'b1000110;
            4'hd: seg = 7'b0100001;
            4'he: seg = 7'b0000110;
            4'hf: seg = 7'b0001110;
            // Blank
            default: seg = 7'b1111111;
        endcase
        return seg;
    endfunction

    // ================================================
    // Digit assembly
    // ================================================
    // Address nibbles on the left, data nibbles on the right
    logic [panel_pkg::num_digits*4-1:0]          digits;
    panel_pkg::seg_t [panel_pkg::num_digits-1:0] segs;

    assign digits = {addr, data};

    always_comb begin
        for (int i = 0; i < panel_pkg::num_digits; i++) begin
            segs[i] = hex_to_seg(digits[i*4 +: 4]);
        end
    end

    // Digit 5 lands in hex5, digit 0 in hex0
    assign hex = panel_pkg::hex_display_t'(segs);

endmodule

`default_nettype wire

/* design/memory_panel_top.sv */
// ================================================
// Memory inspection panel top level
// Host-written byte RAM viewed on six hex digits
// ================================================
`timescale 1ns/1ps
`default_nettype none

module memory_panel_top #(
    parameter int mem_depth = 65536
) (
    input  wire logic               clk,
    input  wire logic               reset_n,
    // Active low, bit 0 up and bit 1 down
    input  wire logic [1:0]         keys,
    // 0 follows host, 1 follows manual address
    input  wire logic               display_mode,
    input  mem_pkg::addr_t          host_addr,
    input  mem_pkg::data_t          host_data,
    output panel_pkg::hex_display_t hex,
    output logic [3:0]              leds
);

    mem_pkg::addr_t   manual_addr;
    mem_pkg::mem_wr_t wr_req;
    mem_pkg::addr_t   rd_addr;
    mem_pkg::data_t   rd_data;

    // ================================================
    // Address sources and RAM
    // ================================================
    address_navigator #(
        .mem_depth (mem_depth)
    ) navigator_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .keys        (keys),
        .manual_addr (manual_addr)
    );

    ram_access_select select_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .display_mode (display_mode),
        .host_addr    (host_addr),
        .host_data    (host_data),
        .manual_addr  (manual_addr),
        .wr_req       (wr_req),
        .rd_addr      (rd_addr)
    );

    dual_port_ram #(
        .mem_depth (mem_depth)
    ) ram_inst (
        .clk     (clk),
        .wr_req  (wr_req),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // ================================================
    // Display and status
    // ================================================
    // Shown address is the one on the read port
    hex_display_driver display_inst (
        .addr (rd_addr),
        .data (rd_data),
        .hex  (hex)
    );

    // Mode, pressed keys and write strobe
    assign leds[0] = display_mode;
    assign leds[1] = ~keys[0];
    assign leds[2] = ~keys[1];
    assign leds[3] = wr_req.en;

endmodule

`default_nettype wire

/* verification/memory_panel_checker.sv */
// ================================================
// Memory panel checker
// Compares the six digits and the LEDs with the expected values
// ================================================
`timescale 1ns/1ps
`default_nettype none

module memory_panel_checker (
    input  wire logic               clk,
    input  wire logic               reset_n,
    // One-cycle request from the stimulus loop
    input  wire logic               check_req,
    input  mem_pkg::addr_t          exp_addr,
    input  mem_pkg::data_t          exp_data,
    // Write strobes expected since the previous request
    input  int                      exp_writes,
    input  wire logic               display_mode,
    // Active low, bit 0 up and bit 1 down
    input  wire logic [1:0]         keys,
    input  panel_pkg::hex_display_t hex,
    input  wire logic [3:0]         leds,
    output int                      error_count,
    output int                      check_count
);

    // Write strobe cycles seen since the last request
    int writes_seen;

    // ================================================
    // Seven-segment reference
    // ================================================
    // Active low, bit 6 is g and bit 0 is a
    localparam panel_pkg::seg_t seg_ref [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
    };

    // Address on the four left digits, byte on the two right ones
    function automatic panel_pkg::hex_display_t expected_display(
        input mem_pkg::addr_t a,
        input mem_pkg::data_t d
    );
        panel_pkg::hex_display_t e;
        e.hex5 = seg_ref[a[15:12]];
        e.hex4 = seg_ref[a[11:8]];
        e.hex3 = seg_ref[a[7:4]];
        e.hex2 = seg_ref[a[3:0]];
        e.hex1 = seg_ref[d[7:4]];
        e.hex0 = seg_ref[d[3:0]];
        return e;
    endfunction

    // ================================================
    // Comparison
    // ================================================
    // Inputs change on the falling edge, so sample on the rising one
    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            error_count = 0;
            check_count = 0;
            writes_seen = 0;
        end else begin
            // Mode LED on every cycle
            if (leds[0] !== display_mode) begin
                $display("Fail at time %0d ns: leds[0] is %b, display mode is %b",
                         $time, leds[0], display_mode);
                error_count = error_count + 1;
            end
            // Pressed keys light their LEDs
            if (leds[2:1] !== ~keys) begin
                $display("Fail at time %0d ns: leds[2:1] is %b, keys are %b",
                         $time, leds[2:1], keys);
                error_count = error_count + 1;
            end
            // Display and write count only on request
            if (check_req) begin
                check_count = check_count + 1;
                if (hex !== expected_display(exp_addr, exp_data)) begin
                    $display("Fail at time %0d ns: display %h, expected address %h data %h",
                             $time, hex, exp_addr, exp_data);
                    error_count = error_count + 1;
                end
                if (writes_seen != exp_writes) begin
                    $display("Fail at time %0d ns: %0d write strobe cycles, expected %0d",
                             $time, writes_seen, exp_writes);
                    error_count = error_count + 1;
                end
                writes_seen = 0;
            end else if (leds[3] === 1'b1) begin
                writes_seen = writes_seen + 1;
            end
        end
    end

endmodule

`default_nettype wire

/* verification/memory_panel_tb.sv */
// ================================================
// Memory panel testbench
// Table of host writes, key presses and mode changes
// ================================================
`timescale 1ns/1ps
`default_nettype none

module memory_panel_tb;

    localparam int clk_period   = 20;
    localparam int reset_cycles = 4;
    localparam int mem_depth    = 65536;
    localparam int num_rows     = 31;
    // Rows at 12 cycles each plus reset, doubled
    localparam int timeout_ns   = (num_rows * 12 * clk_period + reset_cycles * clk_period) * 2;

    // Row operations
    localparam logic [2:0] op_write = 3'd0;
    localparam logic [2:0] op_up    = 3'd1;
    localparam logic [2:0] op_down  = 3'd2;
    localparam logic [2:0] op_mode  = 3'd3;
    localparam logic [2:0] op_hold  = 3'd4;

    // One stimulus row with its expected display
    typedef struct packed {
        logic [2:0]     op;
        mem_pkg::addr_t addr;
        mem_pkg::data_t data;
        logic           rnd_data;
        logic           exp_shadow;
        mem_pkg::addr_t exp_addr;
        mem_pkg::data_t exp_data;
    } row_t;

    logic                    clk;
    logic                    reset_n;
    logic [1:0]              keys;
    logic                    display_mode;
    mem_pkg::addr_t          host_addr;
    mem_pkg::data_t          host_data;
    panel_pkg::hex_display_t hex;
    logic [3:0]              leds;
    logic                    check_req;
    mem_pkg::addr_t          check_addr;
    mem_pkg::data_t          check_data;
    int                      check_writes;
    int                      error_count;
    int                      check_count;
    int                      seed;
    row_t                    rows [num_rows];
    // Expected RAM contents
    mem_pkg::data_t          shadow [mem_depth];

    memory_panel_top #(
        .mem_depth (mem_depth)
    ) dut (
        .clk          (clk),
        .reset_n      (reset_n),
        .keys         (keys),
        .display_mode (display_mode),
        .host_addr    (host_addr),
        .host_data    (host_data),
        .hex          (hex),
        .leds         (leds)
    );

    memory_panel_checker checker_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .check_req    (check_req),
        .exp_addr     (check_addr),
        .exp_data     (check_data),
        .exp_writes   (check_writes),
        .display_mode (display_mode),
        .keys         (keys),
        .hex          (hex),
        .leds         (leds),
        .error_count  (error_count),
        .check_count  (check_count)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    function automatic row_t make_row(
        input logic [2:0] op, input mem_pkg::addr_t addr, input mem_pkg::data_t data,
        input logic rnd, input logic from_shadow,
        input mem_pkg::addr_t exp_a, input mem_pkg::data_t exp_d
    );
        return '{op, addr, data, rnd, from_shadow, exp_a, exp_d};
    endfunction

    // ================================================
    // Stimulus table
    // ================================================
    task automatic load_table();
        // Reset state, then bytes covering every nibble
        rows[0]  = make_row(op_hold,  16'h0000, 8'h00, 1'b0, 1'b0, 16'h0000, 8'h00);
        rows[1]  = make_row(op_write, 16'h0000, 8'h12, 1'b0, 1'b0, 16'h0000, 8'h12);
        rows[2]  = make_row(op_write, 16'h0001, 8'h34, 1'b0, 1'b0, 16'h0001, 8'h34);
        rows[3]  = make_row(op_write, 16'h0002, 8'h56, 1'b0, 1'b0, 16'h0002, 8'h56);
        rows[4]  = make_row(op_write, 16'h0003, 8'h78, 1'b0, 1'b0, 16'h0003, 8'h78);
        rows[5]  = make_row(op_write, 16'h0004, 8'h9a, 1'b0, 1'b0, 16'h0004, 8'h9a);
        rows[6]  = make_row(op_write, 16'h0005, 8'hbc, 1'b0, 1'b0, 16'h0005, 8'hbc);
        rows[7]  = make_row(op_write, 16'h0006, 8'hde, 1'b0, 1'b0, 16'h0006, 8'hde);
        rows[8]  = make_row(op_write, 16'habcd, 8'hf0, 1'b0, 1'b0, 16'habcd, 8'hf0);
        // Random bytes, expected from the shadow
        rows[9]  = make_row(op_write, 16'h0007, 8'h00, 1'b1, 1'b1, 16'h0007, 8'h00);
        rows[10] = make_row(op_write, 16'h0008, 8'h00, 1'b1, 1'b1, 16'h0008, 8'h00);
        rows[11] = make_row(op_write, 16'h0009, 8'h5a, 1'b0, 1'b0, 16'h0009, 8'h5a);
        // Same data at a new address writes nothing
        rows[12] = make_row(op_write, 16'h0003, 8'h5a, 1'b0, 1'b0, 16'h0003, 8'h78);
        rows[13] = make_row(op_write, 16'h0000, 8'h5a, 1'b0, 1'b0, 16'h0000, 8'h12);
        rows[14] = make_row(op_write, 16'h000a, 8'h5a, 1'b0, 1'b0, 16'h000a, 8'h00);
        // Manual mode, down at zero stays put
        rows[15] = make_row(op_mode,  16'h0000, 8'h01, 1'b0, 1'b0, 16'h0000, 8'h12);
        rows[16] = make_row(op_down,  16'h0000, 8'h00, 1'b0, 1'b0, 16'h0000, 8'h12);
        rows[17] = make_row(op_up,    16'h0000, 8'h00, 1'b0, 1'b0, 16'h0001, 8'h34);
        rows[18] = make_row(op_up,    16'h0000, 8'h00, 1'b0, 1'b0, 16'h0002, 8'h56);
        rows[19] = make_row(op_down,  16'h0000, 8'h00, 1'b0, 1'b0, 16'h0001, 8'h34);
        rows[20] = make_row(op_up,    16'h0000, 8'h00, 1'b0, 1'b0, 16'h0002, 8'h56);
        rows[21] = make_row(op_up,    16'h0000, 8'h00, 1'b0, 1'b0, 16'h0003, 8'h78);
        rows[22] = make_row(op_up,    16'h0000, 8'h00, 1'b0, 1'b0, 16'h0004, 8'h9a);
        rows[23] = make_row(op_up,    16'h0000, 8'h00, 1'b0, 1'b0, 16'h0005, 8'hbc);
        rows[24] = make_row(op_up,    16'h0000, 8'h00, 1'b0, 1'b0, 16'h0006, 8'hde);
        rows[25] = make_row(op_up,    16'h0000, 8'h00, 1'b0, 1'b1, 16'h0007, 8'h00);
        rows[26] = make_row(op_up,    16'h0000, 8'h00, 1'b0, 1'b1, 16'h0008, 8'h00);
        // Back to host and out again
        rows[27] = make_row(op_mode,  16'h0000, 8'h00, 1'b0, 1'b0, 16'h000a, 8'h00);
        rows[28] = make_row(op_mode,  16'h0000, 8'h01, 1'b0, 1'b1, 16'h0008, 8'h00);
        rows[29] = make_row(op_down,  16'h0000, 8'h00, 1'b0, 1'b1, 16'h0007, 8'h00);
        rows[30] = make_row(op_hold,  16'h0000, 8'h00, 1'b0, 1'b1, 16'h0007, 8'h00);
    endtask

    // Held low 3 cycles, released 2
    task automatic press_key(input int key_bit);
        keys[key_bit] = 1'b0;
        repeat (3) @(negedge clk);
        keys = 2'b11;
        repeat (2) @(negedge clk);
    endtask

    task automatic apply_row(input row_t r);
        int             rnd;
        int             writes;
        mem_pkg::data_t wdata;
        mem_pkg::data_t want;
        wdata  = r.data;
        writes = 0;
        case (r.op)
            op_write: begin
                if (r.rnd_data) begin
                    rnd = $random(seed);
                    // Odd bytes always differ from the even neighbours
                    wdata = rnd[7:0] | 8'h01;
                end
                // Only a change of data writes
                if (wdata != host_data) begin
                    shadow[r.addr] = wdata;
                    writes = 1;
                end
                host_addr = r.addr;
                host_data = wdata;
            end
            op_up:   press_key(0);
            op_down: press_key(1);
            op_mode: display_mode = r.data[0];
            default: begin
            end
        endcase
        repeat (4) @(negedge clk);
        want = r.exp_shadow ? shadow[r.exp_addr] : r.exp_data;
        check_addr   = r.exp_addr;
        check_data   = want;
        check_writes = writes;
        check_req    = 1'b1;
        @(negedge clk);
        check_req  = 1'b0;
    endtask

    // ================================================
    // Main sequence
    // ================================================
    initial begin
        reset_n      = 1'b0;
        keys         = 2'b11;
        display_mode = 1'b0;
        host_addr    = '0;
        host_data    = '0;
        check_req    = 1'b0;
        check_addr   = '0;
        check_data   = '0;
        check_writes = 0;
        seed         = 32'h278d_d54d;
        for (int i = 0; i < mem_depth; i++) begin
            shadow[i] = '0;
        end
        load_table();
        repeat (reset_cycles) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        for (int i = 0; i < num_rows; i++) begin
            apply_row(rows[i]);
        end
        repeat (2) @(negedge clk);
        $display("Checks: %0d of %0d, errors: %0d", check_count, num_rows, error_count);
        if (error_count == 0 && check_count == num_rows) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(timeout_ns);
        $display("Run timed out after %0d ns without finishing the table", timeout_ns);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
design/mem_pkg.sv
design/panel_pkg.sv
design/address_navigator.sv
design/ram_access_select.sv
design/dual_port_ram.sv
design/hex_display_driver.sv
design/memory_panel_top.sv
verification/memory_panel_checker.sv
verification/memory_panel_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the memory panel testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module memory_panel_tb -o memory_panel_sim \
    || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/memory_panel_sim)
echo "$sim_out"

echo "$sim_out" | grep -q "^Everything OK$" \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation did not pass"; exit 1; }
